// ==== build.f ====
+incdir+source
source/bkram_pkg.sv
source/cart_loader.sv
source/bkram_arbiter.sv
source/bk_sector_seq.sv
source/bkram_top.sv
testbench/bkram_asserts.sv
testbench/bkram_tb.sv

// ==== source/bk_sector_seq.sv ====
// Backup sector sequencer: enable, pending flag and sector save/load over the host handshake
`include "bkram_params.svh"

module bk_sector_seq import bkram_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic                    img_size_nz,
	input  mask_t                   ram_mask,
	input  logic                    bk_load_cmd,
	input  logic                    bk_save_cmd,
	input  logic                    autosave,
	input  logic                    osd_open,
	input  mem_req_t                game_req,
	input  logic                    game_gnt,
	output logic                    bk_ena,
	output logic                    bk_pending,
	output logic                    bk_busy,
	output logic                    sd_req,
	output logic                    sd_dir,
	output lba_t                    sd_lba,
	input  logic                    sd_ack,
	input  logic [`SECTOR_BITS-1:0] buff_addr,
	input  logic                    buff_wr,
	input  logic                    buff_rd,
	input  byte_t                   buff_wdata,
	output mem_req_t                seq_req,
	input  logic                    seq_gnt,
	output logic                    buff_wait
);

	seq_state_t state;
	logic       old_download;
	logic       old_load;
	logic       old_save;
	logic       start_load;
	logic       start_any;
	lba_t       last_lba;

	// ======================================================================
	// Enable and pending flags
	// ======================================================================

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			bk_ena       <= 1'b0;
			bk_pending   <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= bk_load_cmd;
			old_save     <= bk_save_cmd;
			// Save image is mounted by the host before the download ends
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
			else if (cart_download && !old_download)
				bk_ena <= 1'b0;
			if (bk_ena && !osd_open && game_gnt && game_req.we)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ======================================================================
	// Sector FSM
	// ======================================================================

	// Download end with an image behaves like a load command
	assign start_load = (bk_load_cmd & ~old_load) |
		(old_download & ~cart_download & img_size_nz);
	assign start_any  = bk_ena & (state == IDLE) & (start_load |
		(bk_save_cmd & ~old_save) | (autosave & bk_pending & osd_open));

	assign last_lba = (|ram_mask[23:`BK_ADDR_BITS]) ? '1 :
		ram_mask[`BK_ADDR_BITS-1:`SECTOR_BITS];

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state  <= IDLE;
			sd_req <= 1'b0;
			sd_dir <= 1'b0;
			sd_lba <= '0;
		end else begin
			case (state)
				IDLE: if (start_any) begin
					sd_dir <= start_load;
					sd_lba <= '0;
					sd_req <= 1'b1;
					state  <= REQ;
				end
				REQ: if (sd_ack) begin
					sd_req <= 1'b0;
					state  <= XFER;
				end
				// Falling ack closes the sector
				XFER: if (!sd_ack) begin
					if (sd_lba >= last_lba) begin
						state <= IDLE;
					end else begin
						sd_lba <= sd_lba + 1'b1;
						state  <= NEXT;
					end
				end
				NEXT: begin
					sd_req <= 1'b1;
					state  <= REQ;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign bk_busy = (state != IDLE);

	// Host buffer port mapped onto the current sector
	assign seq_req.valid = sd_ack & bk_busy & (buff_wr | buff_rd);
	assign seq_req.addr  = {sd_lba, buff_addr};
	assign seq_req.we    = buff_wr;
	assign seq_req.wdata = buff_wdata;
	assign buff_wait     = seq_req.valid & ~seq_gnt;

endmodule

// ==== source/bkram_arbiter.sv ====
// Fixed-priority arbiter and single-port backup memory array
`include "bkram_params.svh"

module bkram_arbiter import bkram_pkg::*; (
	input  logic     clk_sys,
	input  mem_req_t clr_req,
	input  mem_req_t seq_req,
	input  mem_req_t game_req,
	output logic     clr_gnt,
	output logic     seq_gnt,
	output logic     game_gnt,
	output byte_t    rdata
);

	localparam int MEM_BYTES = 1 << `BK_ADDR_BITS;

	byte_t    mem [MEM_BYTES];
	mem_req_t sel;

	// ======================================================================
	// Grant selection
	// ======================================================================

	// Loader first, then sector sequencer, then game
	always_comb begin
		clr_gnt  = 1'b0;
		seq_gnt  = 1'b0;
		game_gnt = 1'b0;
		sel      = '0;
		if (clr_req.valid) begin
			clr_gnt = 1'b1;
			sel     = clr_req;
		end else if (seq_req.valid) begin
			seq_gnt = 1'b1;
			sel     = seq_req;
		end else if (game_req.valid) begin
			game_gnt = 1'b1;
			sel      = game_req;
		end
	end

	// ======================================================================
	// Memory array
	// ======================================================================

	// Read data is registered and kept until the next read
	always_ff @(posedge clk_sys) begin
		if (sel.valid) begin
			if (sel.we)
				mem[sel.addr] <= sel.wdata;
			else
				rdata <= mem[sel.addr];
		end
	end

endmodule

// ==== source/bkram_params.svh ====
// Backup RAM system parameters: memory size, sector size and header layout
`ifndef BKRAM_PARAMS_SVH
`define BKRAM_PARAMS_SVH

// ==========================================================================
// Backup memory geometry
// ==========================================================================

// 8 KB of battery-backed save RAM
`define BK_ADDR_BITS    13
// 512-byte sectors on the host side
`define SECTOR_BITS     9
`define LBA_BITS        (`BK_ADDR_BITS - `SECTOR_BITS)

// ==========================================================================
// Cartridge download layout
// ==========================================================================

`define CART_ADDR_BITS  25
// Size/type word and region word of the loader header
`define HDR_INFO_ADDR   0
`define HDR_REGION_ADDR 2

`endif

// ==== source/bkram_pkg.sv ====
// Shared types of the backup RAM system: widths, memory requests, header info, FSM states
`include "bkram_params.svh"

package bkram_pkg;

	// Plain vectors with a meaning
	typedef logic [7:0]                   byte_t;
	typedef logic [15:0]                  word_t;
	typedef logic [`BK_ADDR_BITS-1:0]     bk_addr_t;
	typedef logic [`LBA_BITS-1:0]         lba_t;
	typedef logic [`CART_ADDR_BITS-1:0]   cart_addr_t;
	typedef logic [23:0]                  mask_t;

	// One memory client's request, held until granted
	typedef struct packed {
		logic     valid;
		bk_addr_t addr;
		logic     we;
		byte_t    wdata;
	} mem_req_t;

	// Parsed cartridge header
	typedef struct packed {
		byte_t rom_type;
		mask_t rom_mask;
		mask_t ram_mask;
		logic  region;
	} hdr_info_t;

	// Sector sequencer states
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		XFER,
		NEXT
	} seq_state_t;

endpackage

// ==== source/bkram_top.sv ====
// Cartridge memory system top: header loader, backup RAM arbiter and sector sequencer
`include "bkram_params.svh"

module bkram_top import bkram_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    cart_download,
	input  logic                    cart_wr,
	input  cart_addr_t              cart_addr,
	input  word_t                   cart_data,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic                    img_size_nz,
	input  logic                    bk_load_cmd,
	input  logic                    bk_save_cmd,
	input  logic                    autosave,
	input  logic                    osd_open,
	input  mem_req_t                game_req,
	input  logic                    sd_ack,
	input  logic [`SECTOR_BITS-1:0] buff_addr,
	input  logic                    buff_wr,
	input  logic                    buff_rd,
	input  byte_t                   buff_wdata,
	output hdr_info_t               hdr,
	output logic                    bk_ena,
	output logic                    bk_pending,
	output logic                    bk_busy,
	output logic                    game_gnt,
	output byte_t                   game_rdata,
	output logic                    sd_req,
	output logic                    sd_dir,
	output lba_t                    sd_lba,
	output logic                    buff_wait,
	output byte_t                   buff_rdata
);

	mem_req_t clr_req;
	mem_req_t seq_req;
	logic     clr_gnt;
	logic     seq_gnt;
	byte_t    mem_rdata;

	cart_loader loader_i (
		.clk_sys, .reset, .cart_download, .cart_wr, .cart_addr, .cart_data,
		.hdr, .clr_req, .clr_gnt
	);

	bkram_arbiter arbiter_i (
		.clk_sys, .clr_req, .seq_req, .game_req,
		.clr_gnt, .seq_gnt, .game_gnt, .rdata(mem_rdata)
	);

	bk_sector_seq seq_i (
		.clk_sys, .reset, .cart_download, .img_mounted, .img_readonly, .img_size_nz,
		.ram_mask(hdr.ram_mask), .bk_load_cmd, .bk_save_cmd, .autosave, .osd_open,
		.game_req, .game_gnt, .bk_ena, .bk_pending, .bk_busy,
		.sd_req, .sd_dir, .sd_lba, .sd_ack,
		.buff_addr, .buff_wr, .buff_rd, .buff_wdata,
		.seq_req, .seq_gnt, .buff_wait
	);

	// One read bus serves both the game and the host buffer
	assign game_rdata = mem_rdata;
	assign buff_rdata = mem_rdata;

endmodule

// ==== source/cart_loader.sv ====
// Cartridge loader: parses the ROM header and overwrites backup RAM during a download
`include "bkram_params.svh"

module cart_loader import bkram_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       cart_download,
	input  logic       cart_wr,
	input  cart_addr_t cart_addr,
	input  word_t      cart_data,
	output hdr_info_t  hdr,
	output mem_req_t   clr_req,
	input  logic       clr_gnt
);

	// Largest mask the backup memory can hold
	localparam mask_t MEM_MASK = mask_t'((1 << `BK_ADDR_BITS) - 1);

	logic       dl_write;
	logic [3:0] rom_size;
	logic [3:0] ram_size;
	mask_t      rom_mask_nxt;
	mask_t      ram_mask_full;
	mask_t      ram_mask_nxt;
	logic       clr_valid;
	bk_addr_t   clr_addr;
	byte_t      clr_wdata;

	assign dl_write = cart_download & cart_wr;

	// ======================================================================
	// Header decode
	// ======================================================================

	always_comb begin
		// Zero size byte means no header info, fall back to 4 MB ROM and no RAM
		if (cart_data[7:0] == 8'h00) begin
			rom_size = 4'hC;
			ram_size = 4'h0;
		end else begin
			{ram_size, rom_size} = cart_data[7:0];
		end
		rom_mask_nxt  = (mask_t'(1024) << rom_size) - mask_t'(1);
		ram_mask_full = (mask_t'(1024) << ram_size) - mask_t'(1);
		if (ram_size == 4'h0)
			ram_mask_nxt = '0;
		else if (ram_mask_full > MEM_MASK)
			ram_mask_nxt = MEM_MASK;
		else
			ram_mask_nxt = ram_mask_full;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			hdr <= '0;
		end else if (dl_write) begin
			if (cart_addr == cart_addr_t'(`HDR_INFO_ADDR)) begin
				hdr.rom_type <= cart_data[15:8];
				hdr.rom_mask <= rom_mask_nxt;
				hdr.ram_mask <= ram_mask_nxt;
			end
			if (cart_addr == cart_addr_t'(`HDR_REGION_ADDR))
				hdr.region <= cart_data[8];
		end
	end

	// ======================================================================
	// Backup RAM overwrite
	// ======================================================================

	// Top priority client, so the request never waits more than one cycle
	always_ff @(posedge clk_sys) begin
		if (!reset)
			clr_valid <= 1'b0;
		else if (dl_write)
			clr_valid <= 1'b1;
		else if (clr_gnt)
			clr_valid <= 1'b0;
	end

	always_ff @(posedge clk_sys) begin
		if (dl_write) begin
			clr_addr  <= cart_addr[`BK_ADDR_BITS-1:0];
			clr_wdata <= cart_addr[7:0];
		end
	end

	assign clr_req = '{valid: clr_valid, addr: clr_addr, we: 1'b1, wdata: clr_wdata};

endmodule

// ==== testbench/bkram_asserts.sv ====
// Backup RAM checks: single memory grant and four-phase sector handshake rules
module bkram_asserts import bkram_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input logic clr_gnt,
	input logic seq_gnt,
	input logic game_gnt,
	input logic sd_req,
	input logic sd_ack,
	input logic sd_dir,
	input lba_t sd_lba,
	input logic bk_busy
);

	int unsigned assert_fails = 0;

	// One memory access per cycle
	a_one_grant: assert property (@(posedge clk_sys) disable iff (!reset)
		$onehot0({clr_gnt, seq_gnt, game_gnt}))
		else begin
			$error("more than one memory grant in a cycle");
			assert_fails++;
		end

	// Request only drops once the host has acknowledged
	a_req_fall: assert property (@(posedge clk_sys) disable iff (!reset)
		$fell(sd_req) |-> sd_ack)
		else begin
			$error("sd_req fell while sd_ack was low");
			assert_fails++;
		end

	a_req_stable: assert property (@(posedge clk_sys) disable iff (!reset)
		sd_req && $past(sd_req) |-> $stable(sd_lba) && $stable(sd_dir))
		else begin
			$error("sd_lba or sd_dir changed while sd_req was high");
			assert_fails++;
		end

	a_busy_reset: assert property (@(posedge clk_sys) !reset |=> !bk_busy)
		else begin
			$error("bk_busy high in the cycle after reset");
			assert_fails++;
		end

endmodule

bind bkram_top bkram_asserts asserts_i (
	.clk_sys, .reset, .clr_gnt, .seq_gnt, .game_gnt,
	.sd_req, .sd_ack, .sd_dir, .sd_lba, .bk_busy
);

// ==== testbench/bkram_tb.sv ====
// Testbench for the cartridge memory system: host sector model and directed tests
`include "bkram_params.svh"

module bkram_tb import bkram_pkg::*; ();

	localparam int SECTOR_BYTES  = 1 << `SECTOR_BITS;
	localparam int MEM_BYTES     = 1 << `BK_ADDR_BITS;
	// Size byte 8'h2B selects 4 KB of save RAM
	localparam int SAVE_BYTES    = 4096;
	localparam int LAST_LBA      = (SAVE_BYTES - 1) >> `SECTOR_BITS;
	localparam int SECTOR_CYCLES = 2 * SECTOR_BYTES + 16;
	localparam int DL_CYCLES     = MEM_BYTES + 8;
	localparam int GAME_CYCLES   = 4 * 2 * SAVE_BYTES;
	localparam int LIMIT_CYCLES  = 2 * (40 * SECTOR_CYCLES + 2 * DL_CYCLES + GAME_CYCLES);

	logic                    clk_sys;
	logic                    reset;
	logic                    cart_download;
	logic                    cart_wr;
	cart_addr_t              cart_addr;
	word_t                   cart_data;
	logic                    img_mounted;
	logic                    img_readonly;
	logic                    img_size_nz;
	logic                    bk_load_cmd;
	logic                    bk_save_cmd;
	logic                    autosave;
	logic                    osd_open;
	mem_req_t                game_req;
	logic                    sd_ack;
	logic [`SECTOR_BITS-1:0] buff_addr;
	logic                    buff_wr;
	logic                    buff_rd;
	byte_t                   buff_wdata;
	hdr_info_t               hdr;
	logic                    bk_ena;
	logic                    bk_pending;
	logic                    bk_busy;
	logic                    game_gnt;
	byte_t                   game_rdata;
	logic                    sd_req;
	logic                    sd_dir;
	lba_t                    sd_lba;
	logic                    buff_wait;
	byte_t                   buff_rdata;

	// Expected backup RAM contents and host storage
	byte_t       exp_mem [MEM_BYTES];
	logic        exp_known [MEM_BYTES];
	byte_t       host_mem [MEM_BYTES];
	lba_t        lba_q [$];
	logic        dir_q [$];
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;

	bkram_top dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Host storage model
	// ======================================================================

	task automatic serve_sector();
		lba_t lba;
		logic dir;
		int   base;
		int   i;
		lba  = sd_lba;
		dir  = sd_dir;
		base = int'(lba) * SECTOR_BYTES;
		lba_q.push_back(lba);
		dir_q.push_back(dir);
		@(posedge clk_sys);
		#1 sd_ack = 1'b1;
		do @(negedge clk_sys); while (sd_req);
		for (i = 0; i < SECTOR_BYTES; i++) begin
			@(posedge clk_sys);
			#1;
			// Read data of the previous byte is valid now
			if (i > 0 && !dir)
				host_mem[base + i - 1] = buff_rdata;
			buff_addr  = i[`SECTOR_BITS-1:0];
			buff_wr    = dir;
			buff_rd    = !dir;
			buff_wdata = host_mem[base + i];
			do @(negedge clk_sys); while (buff_wait);
		end
		@(posedge clk_sys);
		#1;
		if (!dir)
			host_mem[base + SECTOR_BYTES - 1] = buff_rdata;
		buff_wr = 1'b0;
		buff_rd = 1'b0;
		sd_ack  = 1'b0;
	endtask

	initial begin : host_model
		sd_ack     = 1'b0;
		buff_addr  = '0;
		buff_wr    = 1'b0;
		buff_rd    = 1'b0;
		buff_wdata = '0;
		forever begin
			@(negedge clk_sys);
			if (sd_req)
				serve_sector();
		end
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic report_mismatch(input string test, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		$display("error %s: %s expected %h actual %h", test, what, exp, act);
		test_errors++;
	endtask

	task automatic report_problem(input string test, input string msg);
		$display("%s: %s", test, msg);
		test_errors++;
	endtask

	task automatic end_test(input string test);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: passed", test);
		end else begin
			$display("%s: failed with %0d errors", test, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// Word 0 carries size and type, word 1 the region bit
	task automatic download(input int words, input byte_t size_b, input byte_t type_b,
		input logic region_b, input logic mounted, input logic readonly, input logic size_nz);
		int         w;
		cart_addr_t addr;
		@(posedge clk_sys);
		#1;
		img_mounted   = mounted;
		img_readonly  = readonly;
		img_size_nz   = size_nz;
		cart_download = 1'b1;
		for (w = 0; w < words; w++) begin
			addr = cart_addr_t'(2 * w);
			@(posedge clk_sys);
			#1;
			cart_addr = addr;
			if (w == 0)
				cart_data = {type_b, size_b};
			else if (w == 1)
				cart_data = {7'h00, region_b, 8'h00};
			else
				cart_data = word_t'($urandom);
			cart_wr = 1'b1;
			@(posedge clk_sys);
			#1 cart_wr = 1'b0;
			// Loader copies the low address byte into backup RAM
			exp_mem[addr[`BK_ADDR_BITS-1:0]]   = addr[7:0];
			exp_known[addr[`BK_ADDR_BITS-1:0]] = 1'b1;
		end
		repeat (2) @(posedge clk_sys);
		#1 cart_download = 1'b0;
	endtask

	task automatic game_access(input bk_addr_t addr, input logic we, input byte_t wdata,
		output byte_t rdata, output int waits);
		waits = 0;
		@(posedge clk_sys);
		#1 game_req = '{valid: 1'b1, addr: addr, we: we, wdata: wdata};
		@(negedge clk_sys);
		while (!game_gnt) begin
			waits++;
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		#1 game_req.valid = 1'b0;
		rdata = game_rdata;
	endtask

	task automatic wait_transfer(input string test);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!bk_busy && n < 16) begin
			n++;
			@(negedge clk_sys);
		end
		if (!bk_busy) begin
			report_problem(test, "sector transfer never started");
			return;
		end
		n = 0;
		while (bk_busy && n < 2 * (LAST_LBA + 1) * SECTOR_CYCLES) begin
			n++;
			@(negedge clk_sys);
		end
		if (bk_busy)
			report_problem(test, "sector transfer did not finish in time");
	endtask

	task automatic check_sectors(input string test, input logic dir);
		if (lba_q.size() != LAST_LBA + 1)
			report_mismatch(test, "sector count", LAST_LBA + 1, lba_q.size());
		foreach (lba_q[i]) begin
			if (lba_q[i] !== lba_t'(i))
				report_mismatch(test, "sd_lba", i, lba_q[i]);
			if (dir_q[i] !== dir)
				report_mismatch(test, "sd_dir", dir, dir_q[i]);
		end
		lba_q.delete();
		dir_q.delete();
	endtask

	task automatic check_game_reads(input string test);
		byte_t rd;
		int    waits;
		int    a;
		for (a = 0; a < SAVE_BYTES; a++) begin
			game_access(bk_addr_t'(a), 1'b0, 8'h00, rd, waits);
			if (rd !== host_mem[a])
				report_mismatch(test, "game read", host_mem[a], rd);
			exp_mem[a]   = host_mem[a];
			exp_known[a] = 1'b1;
		end
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic test_header();
		string t = "header";
		byte_t ty;
		ty = byte_t'($urandom);
		download(2, 8'h2B, ty, 1'b1, 1'b0, 1'b0, 1'b0);
		@(negedge clk_sys);
		if (hdr.rom_mask !== (24'd1024 << 11) - 24'd1)
			report_mismatch(t, "rom_mask", (24'd1024 << 11) - 24'd1, hdr.rom_mask);
		if (hdr.ram_mask !== 24'd4095)
			report_mismatch(t, "ram_mask", 24'd4095, hdr.ram_mask);
		if (hdr.rom_type !== ty)
			report_mismatch(t, "rom_type", ty, hdr.rom_type);
		if (hdr.region !== 1'b1)
			report_mismatch(t, "region", 1'b1, hdr.region);
		// Zero size byte falls back to defaults
		download(2, 8'h00, ~ty, 1'b0, 1'b0, 1'b0, 1'b0);
		@(negedge clk_sys);
		if (hdr.rom_mask !== (24'd1024 << 12) - 24'd1)
			report_mismatch(t, "default rom_mask", (24'd1024 << 12) - 24'd1, hdr.rom_mask);
		if (hdr.ram_mask !== 24'd0)
			report_mismatch(t, "default ram_mask", 24'd0, hdr.ram_mask);
		if (hdr.rom_type !== ~ty)
			report_mismatch(t, "rom_type", byte_t'(~ty), hdr.rom_type);
		if (hdr.region !== 1'b0)
			report_mismatch(t, "region", 1'b0, hdr.region);
		end_test(t);
	endtask

	task automatic test_overwrite();
		string    t = "overwrite";
		byte_t    rd;
		byte_t    wd;
		bk_addr_t addr;
		int       waits;
		int       a;
		download(MEM_BYTES / 2, 8'h2B, 8'h01, 1'b0, 1'b1, 1'b0, 1'b0);
		@(negedge clk_sys);
		if (bk_ena !== 1'b1)
			report_mismatch(t, "bk_ena", 1'b1, bk_ena);
		for (a = 0; a < MEM_BYTES; a += 2) begin
			game_access(bk_addr_t'(a), 1'b0, 8'h00, rd, waits);
			if (rd !== byte_t'(a))
				report_mismatch(t, "read data", byte_t'(a), rd);
			// Nothing else competes, so the grant comes at once
			if (waits != 0)
				report_mismatch(t, "grant wait cycles", 0, waits);
		end
		// Writes from inside the menu leave the pending flag alone
		osd_open = 1'b1;
		repeat (32) begin
			addr = bk_addr_t'($urandom);
			wd   = byte_t'($urandom);
			game_access(addr, 1'b1, wd, rd, waits);
			game_access(addr, 1'b0, 8'h00, rd, waits);
			if (rd !== wd)
				report_mismatch(t, "read back", wd, rd);
			exp_mem[addr]   = wd;
			exp_known[addr] = 1'b1;
		end
		osd_open = 1'b0;
		@(negedge clk_sys);
		if (bk_pending !== 1'b0)
			report_mismatch(t, "bk_pending", 1'b0, bk_pending);
		end_test(t);
	endtask

	task automatic test_save();
		string    t = "save";
		byte_t    rd;
		byte_t    wd;
		bk_addr_t addr;
		int       waits;
		int       a;
		repeat (16) begin
			addr = bk_addr_t'($urandom % SAVE_BYTES);
			wd   = byte_t'($urandom);
			game_access(addr, 1'b1, wd, rd, waits);
			exp_mem[addr]   = wd;
			exp_known[addr] = 1'b1;
		end
		@(negedge clk_sys);
		if (bk_pending !== 1'b1)
			report_mismatch(t, "bk_pending", 1'b1, bk_pending);
		lba_q.delete();
		dir_q.delete();
		@(posedge clk_sys);
		#1 bk_save_cmd = 1'b1;
		@(posedge clk_sys);
		#1 bk_save_cmd = 1'b0;
		wait_transfer(t);
		check_sectors(t, 1'b0);
		for (a = 0; a < SAVE_BYTES; a++) begin
			if (exp_known[a] && host_mem[a] !== exp_mem[a])
				report_mismatch(t, "host byte", exp_mem[a], host_mem[a]);
		end
		@(negedge clk_sys);
		if (bk_pending !== 1'b0)
			report_mismatch(t, "bk_pending", 1'b0, bk_pending);
		if (bk_busy !== 1'b0)
			report_mismatch(t, "bk_busy", 1'b0, bk_busy);
		end_test(t);
	endtask

	task automatic test_load();
		string t = "load";
		int    a;
		for (a = 0; a < SAVE_BYTES; a++)
			host_mem[a] = byte_t'($urandom);
		lba_q.delete();
		dir_q.delete();
		@(posedge clk_sys);
		#1 bk_load_cmd = 1'b1;
		@(posedge clk_sys);
		#1 bk_load_cmd = 1'b0;
		wait_transfer(t);
		check_sectors(t, 1'b1);
		check_game_reads(t);
		end_test(t);
	endtask

	task automatic test_autosave();
		string    t = "autosave";
		byte_t    rd;
		byte_t    wd;
		bk_addr_t addr;
		int       waits;
		addr = bk_addr_t'($urandom % SAVE_BYTES);
		wd   = byte_t'($urandom);
		game_access(addr, 1'b1, wd, rd, waits);
		lba_q.delete();
		dir_q.delete();
		@(posedge clk_sys);
		#1;
		osd_open = 1'b1;
		autosave = 1'b1;
		wait_transfer(t);
		check_sectors(t, 1'b0);
		if (host_mem[addr] !== wd)
			report_mismatch(t, "host byte", wd, host_mem[addr]);
		// Still in the menu with nothing left to save
		repeat (20) @(negedge clk_sys);
		if (lba_q.size() != 0 || bk_busy)
			report_problem(t, "autosave without pending writes started a transfer");
		@(posedge clk_sys);
		#1;
		autosave = 1'b0;
		osd_open = 1'b0;
		download(2, 8'h2B, 8'h01, 1'b0, 1'b1, 1'b1, 1'b0);
		@(negedge clk_sys);
		if (bk_ena !== 1'b0)
			report_mismatch(t, "read-only bk_ena", 1'b0, bk_ena);
		@(posedge clk_sys);
		#1 bk_save_cmd = 1'b1;
		@(posedge clk_sys);
		#1 bk_save_cmd = 1'b0;
		bk_load_cmd = 1'b1;
		@(posedge clk_sys);
		#1 bk_load_cmd = 1'b0;
		repeat (20) @(negedge clk_sys);
		if (lba_q.size() != 0)
			report_problem(t, "commands with a read-only image produced a sector request");
		lba_q.delete();
		dir_q.delete();
		end_test(t);
	endtask

	task automatic test_download_load();
		string t = "download load";
		int    a;
		for (a = 0; a < SAVE_BYTES; a++)
			host_mem[a] = byte_t'($urandom);
		lba_q.delete();
		dir_q.delete();
		download(2, 8'h2B, 8'h01, 1'b0, 1'b1, 1'b0, 1'b1);
		wait_transfer(t);
		check_sectors(t, 1'b1);
		check_game_reads(t);
		@(posedge clk_sys);
		#1 img_size_nz = 1'b0;
		end_test(t);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial begin
		reset         = 1'b0;
		cart_download = 1'b0;
		cart_wr       = 1'b0;
		cart_addr     = '0;
		cart_data     = '0;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		img_size_nz   = 1'b0;
		bk_load_cmd   = 1'b0;
		bk_save_cmd   = 1'b0;
		autosave      = 1'b0;
		osd_open      = 1'b0;
		game_req      = '0;
		test_errors   = 0;
		total_errors  = 0;
		tests_run     = 0;
		tests_failed  = 0;
		void'($urandom(32'h6f90));
		foreach (exp_known[i])
			exp_known[i] = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1 reset = 1'b1;
		test_header();
		test_overwrite();
		test_save();
		test_load();
		test_autosave();
		test_download_load();
		$display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, total_errors, dut_i.asserts_i.assert_fails);
		if (tests_failed == 0 && dut_i.asserts_i.assert_fails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin : watchdog
		#(LIMIT_CYCLES * 10);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding",
			LIMIT_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule
